// ==== inverse_golden.txt ====
# name kind a00 a10 a11 a20 a21 a22 l00 l10 l11 l20 l21 l22 inv00 inv10 inv11 inv20 inv21 inv22
# kind 0 plain run, 1 start the cycle after done, 2 extra start while busy, 3 reset mid-run first
ident4 0 0400 0000 0400 0000 0000 0400 0200 0000 0200 0000 0000 0200 0040 0000 0040 0000 0000 0040
ident1 0 0100 0000 0100 0000 0000 0100 0100 0000 0100 0000 0000 0100 0100 0000 0100 0000 0000 0100
diag_149 0 0100 0000 0400 0000 0000 0900 0100 0000 0200 0000 0000 0300 0100 0000 0040 0000 0000 001c
diag_249 0 0200 0000 0400 0000 0000 0900 016a 0000 0200 0000 0000 0300 007f 0000 0040 0000 0000 001c
gen_a 0 0400 0200 0500 0200 0300 0600 0200 0100 0200 0100 0100 0200 0054 ffe8 0050 fff0 ffe0 0040
gen_x4 0 1000 0800 1400 0800 0c00 1800 0400 0200 0400 0200 0200 0400 0015 fffa 0014 fffc fff8 0010
b2b_gen 1 0400 0200 0500 0200 0300 0600 0200 0100 0200 0100 0100 0200 0054 ffe8 0050 fff0 ffe0 0040
b2b_x4 1 1000 0800 1400 0800 0c00 1800 0400 0200 0400 0200 0200 0400 0015 fffa 0014 fffc fff8 0010
busy_diag 2 0200 0000 0400 0000 0000 0900 016a 0000 0200 0000 0000 0300 007f 0000 0040 0000 0000 001c
busy_gen 2 0400 0200 0500 0200 0300 0600 0200 0100 0200 0100 0100 0200 0054 ffe8 0050 fff0 ffe0 0040
reset_x4 3 1000 0800 1400 0800 0c00 1800 0400 0200 0400 0200 0200 0400 0015 fffa 0014 fffc fff8 0010
reset_diag 3 0100 0000 0400 0000 0000 0900 0100 0000 0200 0000 0000 0300 0100 0000 0040 0000 0000 001c
after_rst 1 0400 0000 0400 0000 0000 0400 0200 0000 0200 0000 0000 0200 0040 0000 0040 0000 0000 0040

// ==== filelist.f ====
+incdir+.
inv_pkg.sv
inv_sequencer.sv
isqrt_unit.sv
div_array.sv
chol_unit.sv
lt_inverse_unit.sv
gram_product.sv
matrix_inverse.sv
matrix_inverse_checker.sv
tb_matrix_inverse.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the matrix inverse testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
	--top-module tb_matrix_inverse -o sim_inv || exit 1

out=$(./obj_dir/sim_inv)
echo "$out"
echo "$out" | grep -qx "all tests passed" && exit 0 || exit 1

// ==== tb_matrix_inverse.sv ====
// --------------------------------------------------------------------------
// matrix inverse testbench, golden vectors from a data file
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "inv_defines.svh"

module tb_matrix_inverse;
	import inv_pkg::*;

	logic i;
	logic arst_n;
	logic start;
	mat_t matrix;
	logic busy;
	logic done;
	tri_t lt;
	mat_t inverse;

	int n_tests;
	int n_errors;
	int test_errors;
	logic timed_out;

	matrix_inverse dut (
		.i       (i),
		.arst_n  (arst_n),
		.start   (start),
		.matrix  (matrix),
		.busy    (busy),
		.done    (done),
		.lt      (lt),
		.inverse (inverse)
	);

	initial begin
		i = 1'b0;
		forever #50 i = ~i;
	end

	task automatic check_tri(input string name, input tri_t exp, input tri_t act);
		if (exp !== act) begin
			$display("Error %s lt: expected %h actual %h", name, exp, act);
			test_errors++;
		end
	endtask

	task automatic check_mat(input string name, input mat_t exp, input mat_t act);
		if (exp !== act) begin
			$display("Error %s inverse: expected %h actual %h", name, exp, act);
			test_errors++;
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (exp != act) begin
			$display("Error %s latency: expected %0d actual %0d", name, exp, act);
			test_errors++;
		end
	endtask

	task automatic next_cycle();
		@(posedge i);
		#5;
	endtask

	// symmetric matrix from its lower triangle
	function automatic mat_t sym_mat(input elem_t v[6]);
		mat_t m;
		m[0][0] = v[0];
		m[1][0] = v[1];
		m[0][1] = v[1];
		m[1][1] = v[2];
		m[2][0] = v[3];
		m[0][2] = v[3];
		m[2][1] = v[4];
		m[1][2] = v[4];
		m[2][2] = v[5];
		return m;
	endfunction

	task automatic mid_run_reset(input string name, input mat_t a);
		start = 1'b1;
		matrix = a;
		next_cycle();
		start = 1'b0;
		repeat (30) next_cycle();
		arst_n = 1'b0;
		#5;
		if (busy !== 1'b0 || done !== 1'b0) begin
			$display("%s: busy or done still high during reset", name);
			test_errors++;
		end
		check_tri(name, '0, lt);
		check_mat(name, '0, inverse);
		repeat (2) next_cycle();
		arst_n = 1'b1;
		repeat (2) next_cycle();
	endtask

	task automatic run_vector(input string name, input int kind, input mat_t a,
			input tri_t exp_lt, input mat_t exp_inv);
		int cycles;
		int limit;
		logic got;
		test_errors = 0;
		cycles = 0;
		got = 1'b0;
		limit = `INV_LATENCY + 10;
		if (kind == 1)
			next_cycle();
		else
			repeat (($urandom % 4) + 1) next_cycle();
		if (kind == 3)
			mid_run_reset(name, a);
		start = 1'b1;
		matrix = a;
		while (!got && cycles < limit) begin
			next_cycle();
			cycles++;
			// an ignored start carrying a different matrix
			start = (kind == 2 && cycles == 20);
			matrix = (kind == 2 && cycles == 20) ? sym_mat('{16'h0400, 16'h0, 16'h0400,
				16'h0, 16'h0, 16'h0400}) : '0;
			got = done;
		end
		start = 1'b0;
		if (!got) begin
			$display("timeout: no done pulse in test %s", name);
			timed_out = 1'b1;
		end else begin
			check_count(name, `INV_LATENCY, cycles);
			check_tri(name, exp_lt, lt);
			check_mat(name, exp_inv, inverse);
			n_tests++;
			n_errors += test_errors;
			if (test_errors == 0)
				$display("test %s ok", name);
			else
				$display("test %s bad, %0d mismatches", name, test_errors);
		end
	endtask

	initial begin
		int fd;
		int n;
		int kind;
		string line;
		string name;
		logic [15:0] h[18];
		elem_t a_v[6];
		elem_t l_v[6];
		elem_t v_v[6];
		tri_t exp_lt;
		void'($urandom(77));
		n_tests = 0;
		n_errors = 0;
		timed_out = 1'b0;
		arst_n = 1'b0;
		start = 1'b0;
		matrix = '0;
		repeat (4) @(posedge i);
		#5;
		arst_n = 1'b1;
		fd = $fopen("inverse_golden.txt", "r");
		if (fd == 0) begin
			$display("cannot open inverse_golden.txt");
		end else begin
			while (!$feof(fd) && !timed_out) begin
				n = $fgets(line, fd);
				if (n > 1 && line.getc(0) != "#") begin
					n = $sscanf(line,
						"%s %d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
						name, kind, h[0], h[1], h[2], h[3], h[4], h[5], h[6], h[7], h[8],
						h[9], h[10], h[11], h[12], h[13], h[14], h[15], h[16], h[17]);
					if (n == 20) begin
						for (int j = 0; j < 6; j++) begin
							a_v[j] = elem_t'(h[j]);
							l_v[j] = elem_t'(h[j + 6]);
							v_v[j] = elem_t'(h[j + 12]);
						end
						exp_lt.l00 = l_v[0];
						exp_lt.l10 = l_v[1];
						exp_lt.l11 = l_v[2];
						exp_lt.l20 = l_v[3];
						exp_lt.l21 = l_v[4];
						exp_lt.l22 = l_v[5];
						run_vector(name, kind, sym_mat(a_v), exp_lt, sym_mat(v_v));
					end
				end
			end
			$fclose(fd);
		end
		$display("%0d tests run, %0d errors", n_tests, n_errors);
		if (n_errors == 0 && n_tests > 0 && !timed_out)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// ==== matrix_inverse_checker.sv ====
// --------------------------------------------------------------------------
// control assertions for the matrix inverse sequencer
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module matrix_inverse_checker (
	input logic           i,
	input logic           arst_n,
	input logic           start,
	input logic           busy,
	input logic           done,
	input inv_pkg::step_t step
);

	// done is a single-cycle pulse
	assert property (@(posedge i) disable iff (!arst_n) done |=> !done)
		else $error("done held for more than one cycle");

	// done arrives on the cycle busy drops
	assert property (@(posedge i) disable iff (!arst_n) done |-> (!busy && $past(busy)))
		else $error("done not aligned with the end of busy");

	// a start during a run neither restarts nor stalls the counter
	assert property (@(posedge i) disable iff (!arst_n)
		(start && busy) |=> (done || (busy && step == inv_pkg::step_t'($past(step) + 1'b1))))
		else $error("start while busy disturbed the run");

endmodule

bind inv_sequencer matrix_inverse_checker u_chk (
	.i      (i),
	.arst_n (arst_n),
	.start  (start),
	.busy   (busy),
	.done   (done),
	.step   (step)
);

// ==== matrix_inverse.sv ====
// --------------------------------------------------------------------------
// 3x3 spd matrix inverse top with shared divider and multiplier arrays
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module matrix_inverse (
	input  logic          i,
	input  logic          arst_n,
	input  logic          start,
	input  inv_pkg::mat_t matrix,
	output logic          busy,
	output logic          done,
	output inv_pkg::tri_t lt,
	output inv_pkg::mat_t inverse
);
	import inv_pkg::*;

	step_t step;
	logic en_chol;
	logic en_lt;
	logic en_gram;
	logic sqrt_go;
	div_req_t chol_div;
	div_req_t lt_div;
	div_req_t div_req;
	mul_req_t chol_mul;
	mul_req_t lt_mul;
	mul_req_t mul_req;
	mul_res_t mul_res;
	elem_t [2:0] quot;
	tri_t lt_inv;

	inv_sequencer u_seq (
		.i       (i),
		.arst_n  (arst_n),
		.start   (start),
		.phase   (),
		.step    (step),
		.en_chol (en_chol),
		.en_lt   (en_lt),
		.en_gram (en_gram),
		.sqrt_go (sqrt_go),
		.busy    (busy),
		.done    (done)
	);

	chol_unit u_chol (
		.i       (i),
		.arst_n  (arst_n),
		.en      (en_chol),
		.sqrt_go (sqrt_go),
		.step    (step),
		.matrix  (matrix),
		.div_req (chol_div),
		.mul_req (chol_mul),
		.mul_res (mul_res),
		.quot    (quot),
		.lt      (lt)
	);

	lt_inverse_unit u_ltinv (
		.i       (i),
		.arst_n  (arst_n),
		.en      (en_lt),
		.step    (step),
		.lt      (lt),
		.div_req (lt_div),
		.mul_req (lt_mul),
		.mul_res (mul_res),
		.quot    (quot),
		.lt_inv  (lt_inv)
	);

	gram_product u_gram (
		.i       (i),
		.arst_n  (arst_n),
		.en      (en_gram),
		.step    (step),
		.lt_inv  (lt_inv),
		.inverse (inverse)
	);

	// the idle unit drives zeros so the requests never collide
	assign div_req = chol_div | lt_div;
	assign mul_req = chol_mul | lt_mul;

	div_array u_div (
		.i      (i),
		.arst_n (arst_n),
		.req    (div_req),
		.quot   (quot)
	);

	// shared multipliers, combinational
	always_comb begin
		for (int j = 0; j < 3; j++)
			mul_res[j] = fx_mul(mul_req.a[j], mul_req.b[j]);
	end

endmodule

// ==== gram_product.sv ====
// --------------------------------------------------------------------------
// final product of the transposed inverse triangle with itself
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "inv_defines.svh"

module gram_product (
	input  logic           i,
	input  logic           arst_n,
	input  logic           en,
	input  inv_pkg::step_t step,
	input  inv_pkg::tri_t  lt_inv,
	output inv_pkg::mat_t  inverse
);
	import inv_pkg::*;

	step_t g;
	logic [1:0] row;
	logic [1:0] k;
	mat_t m;
	elem_t [2:0] acc;
	elem_t [2:0] acc_next;

	assign g = step - step_t'(`INV_GRAM_FIRST);

	always_comb begin
		m = '0;
		m[0][0] = lt_inv.l00;
		m[1][0] = lt_inv.l10;
		m[1][1] = lt_inv.l11;
		m[2][0] = lt_inv.l20;
		m[2][1] = lt_inv.l21;
		m[2][2] = lt_inv.l22;
	end

	// three steps per output row, k walks the rows of m
	always_comb begin
		row = 2'd0;
		k = 2'(g);
		if (g >= step_t'(6)) begin
			row = 2'd2;
			k = 2'(g - step_t'(6));
		end else if (g >= step_t'(3)) begin
			row = 2'd1;
			k = 2'(g - step_t'(3));
		end
	end

	always_comb begin
		for (int j = 0; j < 3; j++) begin
			acc_next[j] = fx_mul(m[k][row], m[k][j]);
			if (k != 2'd0)
				acc_next[j] = acc_next[j] + acc[j];
		end
	end

	always_ff @(posedge i) begin
		if (en)
			acc <= acc_next;
	end

	always_ff @(posedge i or negedge arst_n) begin
		if (!arst_n) begin
			inverse <= '0;
		end else if (en && k == 2'd2) begin
			// upper half of the row, mirrored into the column
			for (int j = 0; j < 3; j++) begin
				if (j >= row) begin
					inverse[row][j] <= acc_next[j];
					inverse[j][row] <= acc_next[j];
				end
			end
		end
	end

endmodule

// ==== lt_inverse_unit.sv ====
// --------------------------------------------------------------------------
// lower-triangular inverse of L by forward substitution
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "inv_defines.svh"

module lt_inverse_unit (
	input  logic                 i,
	input  logic                 arst_n,
	input  logic                 en,
	input  inv_pkg::step_t       step,
	input  inv_pkg::tri_t        lt,
	output inv_pkg::div_req_t    div_req,
	output inv_pkg::mul_req_t    mul_req,
	input  inv_pkg::mul_res_t    mul_res,
	input  inv_pkg::elem_t [2:0] quot,
	output inv_pkg::tri_t        lt_inv
);
	import inv_pkg::*;

	// 1.0 in q7.8
	localparam elem_t one = elem_t'(1 << `INV_FRAC);

	step_t off;
	elem_t t0;
	elem_t t1;
	elem_t t2;

	assign off = step - step_t'(`INV_LT_FIRST);

	always_comb begin
		div_req = '0;
		mul_req = '0;
		if (en) begin
			case (off)
				step_t'(0): begin
					div_req.dividend[0] = one;
					div_req.divisor = lt.l00;
				end
				step_t'(1): begin
					div_req.dividend[0] = one;
					div_req.divisor = lt.l11;
				end
				step_t'(2): begin
					div_req.dividend[0] = one;
					div_req.divisor = lt.l22;
				end
				step_t'(3): begin
					// l10*m00, l21*m11, l20*m00
					mul_req.a = {lt.l20, lt.l21, lt.l10};
					mul_req.b = {lt_inv.l00, lt_inv.l11, lt_inv.l00};
				end
				step_t'(4): begin
					mul_req.a = {elem_t'(0), t1, t0};
					mul_req.b = {elem_t'(0), lt_inv.l22, lt_inv.l11};
				end
				step_t'(5): begin
					mul_req.a[0] = lt.l21;
					mul_req.b[0] = lt_inv.l10;
				end
				step_t'(6): begin
					mul_req.a[0] = t2;
					mul_req.b[0] = lt_inv.l22;
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge i) begin
		if (en) begin
			if (off == step_t'(3)) begin
				t0 <= mul_res[0];
				t1 <= mul_res[1];
				t2 <= mul_res[2];
			end
			// l20*m00 + l21*m10
			if (off == step_t'(5))
				t2 <= t2 + mul_res[0];
		end
	end

	always_ff @(posedge i or negedge arst_n) begin
		if (!arst_n) begin
			lt_inv <= '0;
		end else if (en) begin
			case (off)
				step_t'(1): lt_inv.l00 <= quot[0];
				step_t'(2): lt_inv.l11 <= quot[0];
				step_t'(3): lt_inv.l22 <= quot[0];
				step_t'(4): begin
					lt_inv.l10 <= -mul_res[0];
					lt_inv.l21 <= -mul_res[1];
				end
				step_t'(6): lt_inv.l20 <= -mul_res[0];
				default: ;
			endcase
		end
	end

endmodule

// ==== chol_unit.sv ====
// --------------------------------------------------------------------------
// cholesky factoriser, builds L column by column on the shared arrays
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "inv_defines.svh"

module chol_unit (
	input  logic                 i,
	input  logic                 arst_n,
	input  logic                 en,
	input  logic                 sqrt_go,
	input  inv_pkg::step_t       step,
	input  inv_pkg::mat_t        matrix,
	output inv_pkg::div_req_t    div_req,
	output inv_pkg::mul_req_t    mul_req,
	input  inv_pkg::mul_res_t    mul_res,
	input  inv_pkg::elem_t [2:0] quot,
	output inv_pkg::tri_t        lt
);
	import inv_pkg::*;

	// divides follow a root by two steps, quotients one step later
	localparam step_t s_div0 = step_t'(`INV_SQRT_GO0 + `INV_SQRT_CYC + 2);
	localparam step_t s_div1 = step_t'(`INV_SQRT_GO1 + `INV_SQRT_CYC + 2);
	localparam step_t s_q0 = s_div0 + step_t'(1);
	localparam step_t s_q1 = s_div1 + step_t'(1);

	mat_t a;
	// a21 - l20*l10
	elem_t t21;
	// a22 - l20^2
	elem_t t22;
	elem_t rad;
	wide_t radicand;
	elem_t root;
	logic sqrt_done;

	isqrt_unit u_sqrt (
		.i        (i),
		.arst_n   (arst_n),
		.go       (sqrt_go),
		.radicand (radicand),
		.root     (root),
		.done     (sqrt_done)
	);

	assign radicand = wide_t'(rad);

	always_comb begin
		div_req = '0;
		mul_req = '0;
		rad = '0;
		if (en) begin
			case (step)
				step_t'(`INV_SQRT_GO0): rad = a[0][0];
				s_div0: begin
					div_req.dividend[0] = a[1][0];
					div_req.dividend[1] = a[2][0];
					div_req.divisor = lt.l00;
				end
				step_t'(`INV_SQRT_GO1): begin
					// l10^2, l20*l10, l20^2
					mul_req.a = {lt.l20, lt.l20, lt.l10};
					mul_req.b = {lt.l20, lt.l10, lt.l10};
					rad = a[1][1] - mul_res[0];
				end
				s_div1: begin
					div_req.dividend[0] = t21;
					div_req.divisor = lt.l11;
				end
				step_t'(`INV_SQRT_GO2): begin
					mul_req.a[0] = lt.l21;
					mul_req.b[0] = lt.l21;
					rad = t22 - mul_res[0];
				end
				default: ;
			endcase
		end
	end

	// step 0 is the start cycle
	always_ff @(posedge i) begin
		if (en) begin
			if (step == '0)
				a <= matrix;
			if (step == step_t'(`INV_SQRT_GO1)) begin
				t21 <= a[2][1] - mul_res[1];
				t22 <= a[2][2] - mul_res[2];
			end
		end
	end

	always_ff @(posedge i or negedge arst_n) begin
		if (!arst_n) begin
			lt <= '0;
		end else if (en) begin
			if (sqrt_done) begin
				// which diagonal by where the root was started
				if (step < step_t'(`INV_SQRT_GO1))
					lt.l00 <= root;
				else if (step < step_t'(`INV_SQRT_GO2))
					lt.l11 <= root;
				else
					lt.l22 <= root;
			end
			if (step == s_q0) begin
				lt.l10 <= quot[0];
				lt.l20 <= quot[1];
			end
			if (step == s_q1)
				lt.l21 <= quot[0];
		end
	end

endmodule

// ==== div_array.sv ====
// --------------------------------------------------------------------------
// shared divider array, three q7.8 dividends over one divisor
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "inv_defines.svh"

module div_array (
	input  logic                 i,
	input  logic                 arst_n,
	input  inv_pkg::div_req_t    req,
	output inv_pkg::elem_t [2:0] quot
);
	import inv_pkg::*;

	elem_t [2:0] quot_next;

	always_comb begin
		wide_t den;
		wide_t num;
		elem_t d;
		den = wide_t'(req.divisor);
		for (int j = 0; j < 3; j++) begin
			d = req.dividend[j];
			// pre-shift keeps the quotient in q7.8
			num = wide_t'(d) <<< `INV_FRAC;
			if (den == '0)
				quot_next[j] = '0;
			else
				quot_next[j] = elem_t'(num / den);
		end
	end

	// quotients one cycle after the request
	always_ff @(posedge i or negedge arst_n) begin
		if (!arst_n)
			quot <= '0;
		else
			quot <= quot_next;
	end

endmodule

// ==== isqrt_unit.sv ====
// --------------------------------------------------------------------------
// bit-serial q7.8 square root, one result bit per cycle
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "inv_defines.svh"

module isqrt_unit (
	input  logic           i,
	input  logic           arst_n,
	input  logic           go,
	input  inv_pkg::wide_t radicand,
	output inv_pkg::elem_t root,
	output logic           done
);
	import inv_pkg::*;

	localparam int root_w = `INV_SQRT_CYC;
	localparam int op_w = 2 * `INV_SQRT_CYC;
	localparam int cnt_w = $clog2(`INV_SQRT_CYC + 1);

	logic [op_w-1:0] op;
	logic [root_w+2:0] rem;
	logic [root_w+2:0] rem_sh;
	logic [root_w+2:0] trial;
	logic [root_w-1:0] q;
	logic [cnt_w-1:0] cnt;

	// next two radicand bits onto the remainder, trial is 4q+1
	assign rem_sh = {rem[root_w:0], op[op_w-1 -: 2]};
	assign trial = {1'b0, q, 2'b01};
	assign root = elem_t'(q);

	always_ff @(posedge i or negedge arst_n) begin
		if (!arst_n) begin
			op <= '0;
			rem <= '0;
			q <= '0;
			cnt <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (go) begin
				// radicand scaled by 2^8 so the root stays q7.8
				op <= {radicand[`INV_W-1:0], {`INV_FRAC{1'b0}}};
				rem <= '0;
				q <= '0;
				cnt <= cnt_w'(`INV_SQRT_CYC);
			end else if (cnt != '0) begin
				op <= op << 2;
				cnt <= cnt - 1'b1;
				if (rem_sh >= trial) begin
					rem <= rem_sh - trial;
					q <= {q[root_w-2:0], 1'b1};
				end else begin
					rem <= rem_sh;
					q <= {q[root_w-2:0], 1'b0};
				end
				if (cnt == cnt_w'(1))
					done <= 1'b1;
			end
		end
	end

endmodule

// ==== inv_sequencer.sv ====
// --------------------------------------------------------------------------
// matrix inverse control, one step counter that fixes the whole schedule
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "inv_defines.svh"

module inv_sequencer (
	input  logic            i,
	input  logic            arst_n,
	input  logic            start,
	output inv_pkg::phase_t phase,
	output inv_pkg::step_t  step,
	output logic            en_chol,
	output logic            en_lt,
	output logic            en_gram,
	output logic            sqrt_go,
	output logic            busy,
	output logic            done
);
	import inv_pkg::*;

	logic accept;
	logic last_step;

	assign busy = (phase != ph_idle);
	// a start while busy is dropped
	assign accept = start & ~busy;
	assign last_step = (step == step_t'(`INV_LATENCY - 1));

	always_ff @(posedge i or negedge arst_n) begin
		if (!arst_n) begin
			phase <= ph_idle;
			step <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (accept) begin
				// the start cycle itself is step 0
				phase <= ph_chol;
				step <= step_t'(1);
			end else if (busy) begin
				step <= step + step_t'(1);
				if (last_step) begin
					phase <= ph_idle;
					step <= '0;
					done <= 1'b1;
				end else if (step == step_t'(`INV_LT_FIRST - 1)) begin
					phase <= ph_ltinv;
				end else if (step == step_t'(`INV_GRAM_FIRST - 1)) begin
					phase <= ph_gram;
				end else if (step == step_t'(`INV_FIN_FIRST - 1)) begin
					phase <= ph_finish;
				end
			end
		end
	end

	// cholesky also sees the start cycle so it can latch the matrix
	assign en_chol = accept | (phase == ph_chol);
	assign en_lt = (phase == ph_ltinv);
	assign en_gram = (phase == ph_gram);

	// one root per diagonal term
	assign sqrt_go = (phase == ph_chol) &&
		((step == step_t'(`INV_SQRT_GO0)) ||
		(step == step_t'(`INV_SQRT_GO1)) ||
		(step == step_t'(`INV_SQRT_GO2)));

endmodule

// ==== inv_pkg.sv ====
// --------------------------------------------------------------------------
// matrix inverse types and the shared fixed-point product
// --------------------------------------------------------------------------
`include "inv_defines.svh"

package inv_pkg;

	typedef logic signed [`INV_W-1:0] elem_t;
	typedef logic signed [31:0] wide_t;
	typedef logic [`INV_CNT_W-1:0] step_t;

	// row index first
	typedef elem_t [2:0][2:0] mat_t;

	typedef struct packed {
		elem_t l00;
		elem_t l10;
		elem_t l11;
		elem_t l20;
		elem_t l21;
		elem_t l22;
	} tri_t;

	typedef struct packed {
		elem_t [2:0] dividend;
		elem_t       divisor;
	} div_req_t;

	typedef struct packed {
		elem_t [2:0] a;
		elem_t [2:0] b;
	} mul_req_t;

	typedef elem_t [2:0] mul_res_t;

	typedef enum logic [2:0] {
		ph_idle,
		ph_chol,
		ph_ltinv,
		ph_gram,
		ph_finish
	} phase_t;

	// full product, then back to q7.8 by arithmetic shift
	function automatic elem_t fx_mul(elem_t a, elem_t b);
		wide_t p;
		p = wide_t'(a) * wide_t'(b);
		return elem_t'(p >>> `INV_FRAC);
	endfunction

endpackage

// ==== inv_defines.svh ====
// --------------------------------------------------------------------------
// matrix inverse parameters for number format and step schedule
// --------------------------------------------------------------------------
`ifndef INV_DEFINES_SVH
`define INV_DEFINES_SVH

`define INV_W          16
`define INV_FRAC       8
`define INV_CNT_W      7
`define INV_SQRT_CYC   12
`define INV_LATENCY    80

// schedule in counter steps
`define INV_SQRT_GO0   1
`define INV_SQRT_GO1   17
`define INV_SQRT_GO2   33
`define INV_LT_FIRST   47
`define INV_GRAM_FIRST 54
`define INV_FIN_FIRST  63

`endif
